//--- sid_waveform_golden.hex
// cycles(2) wr(1) addr(2) wdata(2) check(1) wav_1(3) wav_2(3) wav_3(3)
// Wr applies to the first cycle of a step, the check is taken after its last edge.
01_1_04_20_1_000_000_000
01_1_01_80_1_000_000_000
01_0_00_00_1_000_000_000
01_0_00_00_1_000_000_000
01_0_00_00_1_008_000_000
01_0_00_00_1_010_000_000
01_1_04_10_1_018_000_000
01_0_00_00_1_020_000_000
01_1_04_14_1_050_000_000
01_0_00_00_1_060_000_000
01_1_0B_40_1_F8E_000_000
01_1_09_01_1_F7E_000_000
01_1_09_00_1_F6E_FFF_000
01_1_0B_60_1_F5E_000_000
01_0_00_00_1_F4E_FFF_000
01_0_00_00_1_F3E_000_000
01_1_04_48_1_F2E_000_000
01_1_02_FF_1_F1E_000_000
01_1_03_0F_1_FFF_000_000
01_1_00_FF_1_FFF_000_000
01_1_01_FF_1_FFF_000_000
01_1_08_10_1_FFF_000_000
01_1_0B_22_1_FFF_000_000
01_1_04_40_1_FFF_000_000
01_0_00_00_1_FFF_001_000
01_0_00_00_1_000_002_000
80_0_00_00_1_000_082_000
01_0_00_00_1_000_000_000
01_0_00_00_1_000_001_000
01_1_12_88_1_000_002_000
01_1_0E_FF_1_000_003_000
01_1_0F_FF_1_000_004_FF0
01_1_12_80_1_000_005_FF0
01_0_00_00_1_000_006_FF0
0A_0_00_00_1_000_010_FF0
01_1_12_A0_1_000_011_FE0
01_0_00_00_1_000_012_FE0
01_0_00_00_1_000_013_0AF
01_0_00_00_1_000_014_0CF
00_0_00_00_0_000_000_000

//--- list.f
sid_pkg.sv
sid_reg_decode.sv
sid_osc_bank.sv
sid_noise.sv
sid_wave_select.sv
sid_waveform.sv
tb_sid_waveform.sv

//--- Bender.yml
package:
  name: sid_waveform

sources:
  - files:
      - sid_pkg.sv
      - sid_reg_decode.sv
      - sid_osc_bank.sv
      - sid_noise.sv
      - sid_wave_select.sv
      - sid_waveform.sv
  - target: test
    files:
      - tb_sid_waveform.sv

//--- tb_sid_waveform.sv
// Testbench for the SID waveform generator, replays register writes and expected outputs.
`default_nettype none
`timescale 1ns/10ps

module tb_sid_waveform;
    import sid_pkg::*;

    localparam int  CLK_PERIOD   = 10;
    localparam int  RESET_CYCLES = 2;
    localparam int  TIMEOUT_PAD  = 20;
    localparam int  MAX_STEPS    = 64;
    localparam int  STEP_W       = 68;

    logic                clk;
    logic                rst_n;
    logic                wr;
    logic [ADDR_W-1:0]   addr;
    logic [7:0]          wdata;
    logic [WAV_W-1:0]    wav_1;
    logic [WAV_W-1:0]    wav_2;
    logic [WAV_W-1:0]    wav_3;

    // One golden line per entry, see the column list in the data file.
    logic [STEP_W-1:0]   steps [0:MAX_STEPS-1];
    int                  num_steps;
    int                  limit;
    int                  cycle_cnt;
    int                  mismatches;
    int                  other_errors;

    sid_waveform uut (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .addr  (addr),
        .wdata (wdata),
        .wav_1 (wav_1),
        .wav_2 (wav_2),
        .wav_3 (wav_3)
    );

    // ------------------------------------------------------------------------
    // Clock
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Compare all three voices at the end of a step.
    task automatic compare_outputs(input int idx, input logic [STEP_W-1:0] line);
        logic [WAV_W-1:0] exp_1;
        logic [WAV_W-1:0] exp_2;
        logic [WAV_W-1:0] exp_3;
        exp_1 = line[35:24];
        exp_2 = line[23:12];
        exp_3 = line[11:0];
        assert (wav_1 === exp_1 && wav_2 === exp_2 && wav_3 === exp_3) else begin
            $display("mismatch at %0t: step %0d expected %h %h %h, got %h %h %h",
                     $time, idx, exp_1, exp_2, exp_3, wav_1, wav_2, wav_3);
            mismatches++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus and checks
    // ------------------------------------------------------------------------
    initial begin
        logic [STEP_W-1:0] line;
        int                total;
        rst_n        = 1'b0;
        wr           = 1'b0;
        addr         = '0;
        wdata        = '0;
        limit        = 0;
        mismatches   = 0;
        other_errors = 0;
        num_steps    = 0;
        total        = 0;
        $readmemh("sid_waveform_golden.hex", steps);
        // A line with zero cycles closes the list.
        while (num_steps < MAX_STEPS && !$isunknown(steps[num_steps]) &&
               steps[num_steps][67:60] != 8'd0) begin
            total = total + int'(steps[num_steps][67:60]);
            num_steps++;
        end
        if (num_steps == 0) begin
            $display("golden file holds no test steps");
            other_errors++;
        end
        limit = total + RESET_CYCLES + TIMEOUT_PAD;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < num_steps; i++) begin
            line = steps[i];
            @(posedge clk);
            wr    <= line[56];
            addr  <= line[52:48];
            wdata <= line[47:40];
            // Long steps idle after their first cycle.
            repeat (int'(line[67:60]) - 1) begin
                @(posedge clk);
                wr <= 1'b0;
            end
            @(negedge clk);
            if (line[36]) begin
                compare_outputs(i, line);
            end
        end

        $display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, the limit follows from the cycle counts in the golden file.
    initial begin
        cycle_cnt = 0;
        while (limit == 0 || cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("mismatches: %0d, other errors: %0d", mismatches, other_errors + 1);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sid_waveform.sv
// SID three-voice waveform generator top, register decode to oscillators, noise and output.
`default_nettype none
`timescale 1ns/10ps

module sid_waveform (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr,
    input  logic [sid_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                wdata,
    output logic [sid_pkg::WAV_W-1:0]  wav_1,
    output logic [sid_pkg::WAV_W-1:0]  wav_2,
    output logic [sid_pkg::WAV_W-1:0]  wav_3
);
    import sid_pkg::*;

    logic [FREQ_W-1:0]  freq_1, freq_2, freq_3;
    logic [PW_W-1:0]    pw_1, pw_2, pw_3;
    control_u           ctrl_1, ctrl_2, ctrl_3;
    logic [OSC_W-1:0]   osc_1, osc_2, osc_3;
    logic [NOISE_W-1:0] noise_1, noise_2, noise_3;

    // ------------------------------------------------------------------------
    // Register writes
    // ------------------------------------------------------------------------
    sid_reg_decode u_decode (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (wr),
        .addr   (addr),
        .wdata  (wdata),
        .freq_1 (freq_1),
        .freq_2 (freq_2),
        .freq_3 (freq_3),
        .pw_1   (pw_1),
        .pw_2   (pw_2),
        .pw_3   (pw_3),
        .ctrl_1 (ctrl_1),
        .ctrl_2 (ctrl_2),
        .ctrl_3 (ctrl_3)
    );

    // Phase accumulators, one edge after the write.
    sid_osc_bank u_osc (
        .clk    (clk),
        .rst_n  (rst_n),
        .freq_1 (freq_1),
        .freq_2 (freq_2),
        .freq_3 (freq_3),
        .ctrl_1 (ctrl_1),
        .ctrl_2 (ctrl_2),
        .ctrl_3 (ctrl_3),
        .osc_1  (osc_1),
        .osc_2  (osc_2),
        .osc_3  (osc_3)
    );

    // Noise LFSRs follow the oscillators.
    sid_noise u_noise (
        .clk     (clk),
        .rst_n   (rst_n),
        .osc_1   (osc_1),
        .osc_2   (osc_2),
        .osc_3   (osc_3),
        .ctrl_1  (ctrl_1),
        .ctrl_2  (ctrl_2),
        .ctrl_3  (ctrl_3),
        .noise_1 (noise_1),
        .noise_2 (noise_2),
        .noise_3 (noise_3)
    );

    // Output stage, one more edge.
    sid_wave_select u_select (
        .clk     (clk),
        .rst_n   (rst_n),
        .osc_1   (osc_1),
        .osc_2   (osc_2),
        .osc_3   (osc_3),
        .pw_1    (pw_1),
        .pw_2    (pw_2),
        .pw_3    (pw_3),
        .ctrl_1  (ctrl_1),
        .ctrl_2  (ctrl_2),
        .ctrl_3  (ctrl_3),
        .noise_1 (noise_1),
        .noise_2 (noise_2),
        .noise_3 (noise_3),
        .wav_1   (wav_1),
        .wav_2   (wav_2),
        .wav_3   (wav_3)
    );

endmodule

`default_nettype wire

//--- sid_wave_select.sv
// SID waveform select, builds saw, triangle, pulse and noise and registers the voice outputs.
`default_nettype none
`timescale 1ns/10ps

module sid_wave_select (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [sid_pkg::OSC_W-1:0]   osc_1,
    input  logic [sid_pkg::OSC_W-1:0]   osc_2,
    input  logic [sid_pkg::OSC_W-1:0]   osc_3,
    input  logic [sid_pkg::PW_W-1:0]    pw_1,
    input  logic [sid_pkg::PW_W-1:0]    pw_2,
    input  logic [sid_pkg::PW_W-1:0]    pw_3,
    input  sid_pkg::control_u          ctrl_1,
    input  sid_pkg::control_u          ctrl_2,
    input  sid_pkg::control_u          ctrl_3,
    input  logic [sid_pkg::NOISE_W-1:0] noise_1,
    input  logic [sid_pkg::NOISE_W-1:0] noise_2,
    input  logic [sid_pkg::NOISE_W-1:0] noise_3,
    output logic [sid_pkg::WAV_W-1:0]   wav_1,
    output logic [sid_pkg::WAV_W-1:0]   wav_2,
    output logic [sid_pkg::WAV_W-1:0]   wav_3
);
    import sid_pkg::*;

    logic [OSC_W-1:0]      osc      [NUM_VOICES];
    logic [PW_W-1:0]       pw       [NUM_VOICES];
    control_u              ctrl     [NUM_VOICES];
    logic [NOISE_W-1:0]    noise    [NUM_VOICES];
    logic [WAV_W-1:0]      saw      [NUM_VOICES];
    logic [WAV_W-1:0]      tri_wav  [NUM_VOICES];
    logic [WAV_W-1:0]      wav_next [NUM_VOICES];
    logic [WAV_W-1:0]      wav      [NUM_VOICES];
    logic [NUM_VOICES-1:0] tri_msb;
    logic [NUM_VOICES-1:0] pulse;

    assign osc   = '{osc_1, osc_2, osc_3};
    assign pw    = '{pw_1, pw_2, pw_3};
    assign ctrl  = '{ctrl_1, ctrl_2, ctrl_3};
    assign noise = '{noise_1, noise_2, noise_3};

    // ------------------------------------------------------------------------
    // Waveform generators
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_VOICES; i++) begin
            // Sawtooth is the top of the phase.
            saw[i]     = osc[i][OSC_W-1 -: WAV_W];
            // Ring modulation swaps the MSB term for the source MSB.
            tri_msb[i] = osc[i][OSC_W-1] ^
                         (ctrl[i].flags.ring_mod & ~osc[ring_src(i)][OSC_W-1]);
            // Fold the lower 11 bits, then move them up one place.
            tri_wav[i] = {osc[i][OSC_W-2 -: WAV_W-1] ^ {(WAV_W - 1){tri_msb[i]}}, 1'b0};
            // Test forces pulse high.
            pulse[i]   = (saw[i] >= pw[i]) | ctrl[i].flags.test;
        end
    end

    // ------------------------------------------------------------------------
    // Selector
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_VOICES; i++) begin
            // Only single selections pass; combinations read zero.
            case ({ctrl[i].flags.pulse, ctrl[i].flags.sawtooth, ctrl[i].flags.triangle})
                3'b100:  wav_next[i] = {WAV_W{pulse[i]}};
                3'b010:  wav_next[i] = saw[i];
                3'b001:  wav_next[i] = tri_wav[i];
                default: wav_next[i] = '0;
            endcase
            if (ctrl[i].flags.noise) begin
                if (!ctrl[i].flags.pulse && !ctrl[i].flags.sawtooth &&
                    !ctrl[i].flags.triangle) begin
                    wav_next[i] = {noise[i], (WAV_W - NOISE_W)'(0)};
                end else begin
                    // Noise can only pull the upper bits low.
                    wav_next[i][WAV_W-1 -: NOISE_W] = wav_next[i][WAV_W-1 -: NOISE_W] &
                                                      noise[i];
                end
            end
        end
    end

    // Output registers.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                wav[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                wav[i] <= wav_next[i];
            end
        end
    end

    assign wav_1 = wav[0];
    assign wav_2 = wav[1];
    assign wav_3 = wav[2];

    // Noise on its own leaves the low nibble clear one edge later.
    for (genvar g = 0; g < NUM_VOICES; g++) begin : g_noise_chk
        a_noise_nibble: assert property (
            @(posedge clk) disable iff (!rst_n)
            ctrl[g].flags.noise && !ctrl[g].flags.pulse && !ctrl[g].flags.sawtooth &&
            !ctrl[g].flags.triangle |=> wav[g][WAV_W-NOISE_W-1:0] == '0
        );
    end

endmodule

`default_nettype wire

//--- sid_noise.sv
// SID noise generator, three 23-bit LFSRs clocked by oscillator bit 19.
`default_nettype none
`timescale 1ns/10ps

module sid_noise (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [sid_pkg::OSC_W-1:0]   osc_1,
    input  logic [sid_pkg::OSC_W-1:0]   osc_2,
    input  logic [sid_pkg::OSC_W-1:0]   osc_3,
    input  sid_pkg::control_u          ctrl_1,
    input  sid_pkg::control_u          ctrl_2,
    input  sid_pkg::control_u          ctrl_3,
    output logic [sid_pkg::NOISE_W-1:0] noise_1,
    output logic [sid_pkg::NOISE_W-1:0] noise_2,
    output logic [sid_pkg::NOISE_W-1:0] noise_3
);
    import sid_pkg::*;

    logic [OSC_W-1:0]      osc   [NUM_VOICES];
    control_u              ctrl  [NUM_VOICES];
    logic [LFSR_W-1:0]     lfsr  [NUM_VOICES];
    logic [NOISE_W-1:0]    noise [NUM_VOICES];
    logic [NUM_VOICES-1:0] bit_prev;
    logic [NUM_VOICES-1:0] bit_rise;

    assign osc  = '{osc_1, osc_2, osc_3};
    assign ctrl = '{ctrl_1, ctrl_2, ctrl_3};

    // Rise of the clocking bit against its copy from the last edge.
    always_comb begin
        for (int i = 0; i < NUM_VOICES; i++) begin
            bit_rise[i] = ~bit_prev[i] & osc[i][NOISE_BIT];
        end
    end

    // Shift registers.
    // Test holds them full of ones, same as reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_prev <= '0;
            for (int i = 0; i < NUM_VOICES; i++) begin
                lfsr[i] <= '1;
            end
        end else begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                bit_prev[i] <= osc[i][NOISE_BIT];
                if (ctrl[i].flags.test) begin
                    lfsr[i] <= '1;
                end else if (bit_rise[i]) begin
                    lfsr[i] <= {lfsr[i][LFSR_W-2:0], lfsr[i][22] ^ lfsr[i][17]};
                end
            end
        end
    end

    // Output taps, MSB first.
    always_comb begin
        for (int i = 0; i < NUM_VOICES; i++) begin
            noise[i] = {lfsr[i][20], lfsr[i][18], lfsr[i][14], lfsr[i][11],
                        lfsr[i][9],  lfsr[i][5],  lfsr[i][2],  lfsr[i][0]};
        end
    end

    assign noise_1 = noise[0];
    assign noise_2 = noise[1];
    assign noise_3 = noise[2];

endmodule

`default_nettype wire

//--- sid_osc_bank.sv
// SID oscillator bank, three 24-bit phase accumulators with test and hard sync.
`default_nettype none
`timescale 1ns/10ps

module sid_osc_bank (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [sid_pkg::FREQ_W-1:0] freq_1,
    input  logic [sid_pkg::FREQ_W-1:0] freq_2,
    input  logic [sid_pkg::FREQ_W-1:0] freq_3,
    input  sid_pkg::control_u         ctrl_1,
    input  sid_pkg::control_u         ctrl_2,
    input  sid_pkg::control_u         ctrl_3,
    output logic [sid_pkg::OSC_W-1:0]  osc_1,
    output logic [sid_pkg::OSC_W-1:0]  osc_2,
    output logic [sid_pkg::OSC_W-1:0]  osc_3
);
    import sid_pkg::*;

    logic [FREQ_W-1:0]     freq     [NUM_VOICES];
    control_u              ctrl     [NUM_VOICES];
    logic [OSC_W-1:0]      osc      [NUM_VOICES];
    logic [OSC_W-1:0]      osc_add  [NUM_VOICES];
    logic [OSC_W-1:0]      osc_next [NUM_VOICES];
    logic [NUM_VOICES-1:0] msb_up;
    logic [NUM_VOICES-1:0] synced;
    logic [NUM_VOICES-1:0] clr;

    assign freq = '{freq_1, freq_2, freq_3};
    assign ctrl = '{ctrl_1, ctrl_2, ctrl_3};

    // ------------------------------------------------------------------------
    // Next phase and sync ring
    // ------------------------------------------------------------------------
    always_comb begin
        // Plain accumulate, and the MSB rise it would produce.
        for (int i = 0; i < NUM_VOICES; i++) begin
            osc_add[i] = osc[i] + OSC_W'(freq[i]);
            msb_up[i]  = ~osc[i][OSC_W-1] & osc_add[i][OSC_W-1];
        end
        // A voice counts as synced when test is set or its source MSB rises.
        for (int i = 0; i < NUM_VOICES; i++) begin
            synced[i] = ctrl[i].flags.test |
                        (ctrl[i].flags.sync & msb_up[ring_src(i)]);
        end
        // A source that is itself synced this edge has its MSB zeroed,
        // so it does not pass the sync on.
        // When all three sync each other, none of them resets.
        for (int i = 0; i < NUM_VOICES; i++) begin
            clr[i] = ctrl[i].flags.test |
                     (ctrl[i].flags.sync & msb_up[ring_src(i)] & ~synced[ring_src(i)]);
            osc_next[i] = clr[i] ? '0 : osc_add[i];
        end
    end

    // Accumulators.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                osc[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                osc[i] <= osc_next[i];
            end
        end
    end

    assign osc_1 = osc[0];
    assign osc_2 = osc[1];
    assign osc_3 = osc[2];

    // Test held at one edge leaves the oscillator at zero after it.
    for (genvar g = 0; g < NUM_VOICES; g++) begin : g_test_chk
        a_test_zero: assert property (
            @(posedge clk) disable iff (!rst_n) ctrl[g].flags.test |=> osc[g] == '0
        );
    end

endmodule

`default_nettype wire

//--- sid_reg_decode.sv
// SID register decode, turns byte writes into per-voice frequency, pulse width and control.
`default_nettype none
`timescale 1ns/10ps

module sid_reg_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr,
    input  logic [sid_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                wdata,
    output logic [sid_pkg::FREQ_W-1:0] freq_1,
    output logic [sid_pkg::FREQ_W-1:0] freq_2,
    output logic [sid_pkg::FREQ_W-1:0] freq_3,
    output logic [sid_pkg::PW_W-1:0]   pw_1,
    output logic [sid_pkg::PW_W-1:0]   pw_2,
    output logic [sid_pkg::PW_W-1:0]   pw_3,
    output sid_pkg::control_u         ctrl_1,
    output sid_pkg::control_u         ctrl_2,
    output sid_pkg::control_u         ctrl_3
);
    import sid_pkg::*;

    logic [FREQ_W-1:0]  freq_r [NUM_VOICES];
    logic [PW_W-1:0]    pw_r   [NUM_VOICES];
    control_u           ctrl_r [NUM_VOICES];

    logic               hit;
    logic [VOICE_W-1:0] voice;
    logic [OFS_W-1:0]   offset;

    // Address split into voice and offset.
    // Offsets 5 and 6, and everything from 21 up, leave hit low.
    always_comb begin
        hit    = 1'b0;
        voice  = '0;
        offset = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (addr >= ADDR_W'(v * REG_STRIDE) && addr < ADDR_W'((v + 1) * REG_STRIDE)) begin
                voice  = VOICE_W'(v);
                offset = OFS_W'(addr - ADDR_W'(v * REG_STRIDE));
                hit    = offset <= OFS_CONTROL;
            end
        end
    end

    // Byte register file.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                freq_r[v] <= '0;
                pw_r[v]   <= '0;
                ctrl_r[v] <= '0;
            end
        end else if (wr && hit) begin
            case (offset)
                OFS_FREQ_LO: freq_r[voice][7:0]  <= wdata;
                OFS_FREQ_HI: freq_r[voice][15:8] <= wdata;
                OFS_PW_LO:   pw_r[voice][7:0]    <= wdata;
                // Upper nibble of the pulse width byte does not exist.
                OFS_PW_HI:   pw_r[voice][11:8]   <= wdata[3:0];
                // Control byte goes in through the raw view.
                default:     ctrl_r[voice].raw   <= wdata;
            endcase
        end
    end

    assign freq_1 = freq_r[0];
    assign freq_2 = freq_r[1];
    assign freq_3 = freq_r[2];
    assign pw_1   = pw_r[0];
    assign pw_2   = pw_r[1];
    assign pw_3   = pw_r[2];
    assign ctrl_1 = ctrl_r[0];
    assign ctrl_2 = ctrl_r[1];
    assign ctrl_3 = ctrl_r[2];

    // Write data must be fully known whenever it is strobed in.
    a_wdata_known: assert property (
        @(posedge clk) disable iff (!rst_n) wr |-> !$isunknown(wdata)
    );

endmodule

`default_nettype wire

//--- sid_pkg.sv
// SID waveform package with widths, register map, control byte types and the voice ring.
`default_nettype none

package sid_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int NUM_VOICES = 3;
    localparam int VOICE_W    = $clog2(NUM_VOICES);
    localparam int OSC_W      = 24;
    localparam int WAV_W      = 12;
    localparam int FREQ_W     = 16;
    localparam int PW_W       = 12;
    localparam int LFSR_W     = 23;
    localparam int NOISE_W    = 8;

    // ------------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------------
    localparam int ADDR_W     = 5;
    localparam int OFS_W      = 3;
    // Seven byte registers per voice, five of them in use.
    localparam int REG_STRIDE = 7;

    localparam logic [OFS_W-1:0] OFS_FREQ_LO = 3'd0;
    localparam logic [OFS_W-1:0] OFS_FREQ_HI = 3'd1;
    localparam logic [OFS_W-1:0] OFS_PW_LO   = 3'd2;
    localparam logic [OFS_W-1:0] OFS_PW_HI   = 3'd3;  // low nibble only
    localparam logic [OFS_W-1:0] OFS_CONTROL = 3'd4;

    // Oscillator bit whose rise clocks the noise LFSR.
    localparam int NOISE_BIT  = 19;

    // Control register, MSB first as on the chip.
    typedef struct packed {
        logic noise;
        logic pulse;
        logic sawtooth;
        logic triangle;
        logic test;
        logic ring_mod;
        logic sync;
        logic gate;
    } control_t;

    // Written as a raw byte, read back as flags.
    typedef union packed {
        logic [7:0] raw;
        control_t   flags;
    } control_u;

    // Sync and ring modulation source of a voice.
    // Voice 1 follows voice 3, voice 2 follows voice 1, voice 3 follows voice 2.
    function automatic int ring_src(int v);
        return (v + NUM_VOICES - 1) % NUM_VOICES;
    endfunction

endpackage

`default_nettype wire
